/* build.f */
+incdir+src
+incdir+tests
src/iCachePkg.sv
src/wayRam.sv
src/cacheWay.sv
src/plruTracker.sv
src/fetchControl.sv
src/fetchICache.sv
tests/iCacheTb.sv

/* tests/iCacheTbLib.svh */
`ifndef ICACHE_TB_LIB_SVH
`define ICACHE_TB_LIB_SVH

// Taps 32, 22, 2 and 1
function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Memory word at a byte address
function automatic InstT memWord(input AddrT byteAddr);
    return byteAddr ^ 32'h5A5A_C3C3;
endfunction

function automatic AddrT lineAlign(input AddrT a);
    return {a[`ICACHE_ADDR_W-1:`ICACHE_SET_LSB], 4'h0};
endfunction

function automatic LineT lineData(input AddrT a);
    LineT data;
    for (int k = 0; k < 4; k++) begin
        data[k] = memWord(lineAlign(a) + AddrT'(4 * k));
    end
    return data;
endfunction

////////////////////
// Tag and tree model
////////////////////

TagT  modelTag   [`ICACHE_SETS][`ICACHE_WAYS];
logic modelValid [`ICACHE_SETS][`ICACHE_WAYS];
PlruT modelTree  [`ICACHE_SETS];

function automatic int setOf(input AddrT a);
    return int'(a[`ICACHE_TAG_LSB-1:`ICACHE_SET_LSB]);
endfunction

function automatic void clearModel();
    for (int s = 0; s < `ICACHE_SETS; s++) begin
        modelTree[s] = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            modelValid[s][w] = 1'b0;
        end
    end
endfunction

// Hitting way, or -1 on a miss
function automatic int predictWay(input AddrT a);
    int  s;
    TagT t;
    s = setOf(a);
    t = a[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
        if (modelValid[s][w] && modelTag[s][w] == t) begin
            return w;
        end
    end
    return -1;
endfunction

function automatic void touchTree(input AddrT a, input int way);
    int s;
    s = setOf(a);
    if (way < 2) begin
        modelTree[s][2] = 1'b1;
        modelTree[s][0] = (way == 0);
    end else begin
        modelTree[s][2] = 1'b0;
        modelTree[s][1] = (way == 2);
    end
endfunction

// Empty ways first, then the tree
function automatic int chooseVictim(input int s);
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
        if (!modelValid[s][w]) begin
            return w;
        end
    end
    if (modelTree[s][2]) begin
        return modelTree[s][1] ? 3 : 2;
    end
    return modelTree[s][0] ? 1 : 0;
endfunction

function automatic void installLine(input AddrT a);
    int way;
    way = chooseVictim(setOf(a));
    modelTag[setOf(a)][way] = a[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
    modelValid[setOf(a)][way] = 1'b1;
    touchTree(a, way);
endfunction

////////////////////
// Compares
////////////////////

task automatic compareInst(input string name, input InstT got, input InstT exp);
    if (got !== exp) begin
        abortRun($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
    end
endtask

task automatic compareAddr(input string name, input AddrT got, input AddrT exp);
    if (got !== exp) begin
        abortRun($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
    end
endtask

task automatic compareBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        abortRun($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
    end
endtask

`endif

/* tests/iCacheTb.sv */
`timescale 1ns/1ps

`include "icache_macros.svh"

module iCacheTb
    import iCachePkg::*;
();

    localparam int StepTimeout = 200;
    localparam int IdleTimeout = 20000;

    logic clk;
    logic rst;
    AddrT pc;
    logic slot0Valid;
    AddrT slot0Pc;
    InstT slot0Inst;
    logic slot1Valid;
    AddrT slot1Pc;
    InstT slot1Inst;
    logic stall;
    logic memReqValid;
    AddrT memReqAddr;
    logic memReqReady;
    logic memRespValid;
    LineT memRespLine;

    logic [31:0] lfsr = 32'd32;
    AddrT        randomPcs [200];

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    `include "iCacheTbLib.svh"

    function automatic int unsigned takeBits(input int n);
        int unsigned bits;
        bits = 0;
        for (int i = 0; i < n; i++) begin
            bits = (bits << 1) | lfsr[0];
            lfsr = lfsrStep(lfsr);
        end
        return bits;
    endfunction

    fetchICache i_dut (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .slot0Valid   (slot0Valid),
        .slot0Pc      (slot0Pc),
        .slot0Inst    (slot0Inst),
        .slot1Valid   (slot1Valid),
        .slot1Pc      (slot1Pc),
        .slot1Inst    (slot1Inst),
        .stall        (stall),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memReqReady  (memReqReady),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Random ready while idle, then 1 to 4 cycles to the response
    initial begin : memResponder
        AddrT reqAddr;
        int   idle;
        memReqReady  = 1'b0;
        memRespValid = 1'b0;
        memRespLine  = '0;
        idle = 0;
        forever begin
            @(negedge clk);
            if (memReqValid && memReqReady) begin
                reqAddr = memReqAddr;
                idle = 0;
                @(posedge clk);
                #1;
                memReqReady = 1'b0;
                repeat (takeBits(2)) begin
                    @(posedge clk);
                    #1;
                end
                memRespValid = 1'b1;
                memRespLine  = lineData(reqAddr);
                @(posedge clk);
                #1;
                memRespValid = 1'b0;
            end else begin
                idle++;
                if (idle > IdleTimeout) begin
                    abortRun("no memory request arrived for too long");
                end
                @(posedge clk);
                #1;
                memReqReady = (takeBits(2) == 0);
            end
        end
    end

    ////////////////////
    // Checker
    ////////////////////

    logic lookupValid;
    AddrT lookupAddr;
    logic missOpen;
    AddrT missAddr;
    int   missCycles;
    logic afterReset;
    int   hits = 0;
    int   misses = 0;

    task automatic expectPair(input AddrT a);
        AddrT base;
        base = {a[`ICACHE_ADDR_W-1:3], 3'b000};
        compareBit("slot0Valid", slot0Valid, !a[2]);
        compareBit("slot1Valid", slot1Valid, 1'b1);
        compareAddr("slot1Pc", slot1Pc, base + 32'd4);
        compareInst("slot1Inst", slot1Inst, memWord(base + 32'd4));
        if (!a[2]) begin
            compareAddr("slot0Pc", slot0Pc, base);
            compareInst("slot0Inst", slot0Inst, memWord(base));
        end
    endtask

    task automatic expectStalled();
        compareBit("stall", stall, 1'b1);
        compareBit("slot0Valid", slot0Valid, 1'b0);
        compareBit("slot1Valid", slot1Valid, 1'b0);
    endtask

    always @(negedge clk) begin : resultCheck
        int way;
        if (rst) begin
            clearModel();
            lookupValid = 1'b0;
            missOpen    = 1'b0;
            afterReset  = 1'b1;
        end else begin
            if (afterReset) begin
                compareBit("stall", stall, 1'b0);
                compareBit("memReqValid", memReqValid, 1'b0);
                compareBit("slot0Valid", slot0Valid, 1'b0);
                compareBit("slot1Valid", slot1Valid, 1'b0);
                afterReset = 1'b0;
            end
            if (missOpen) begin
                missCycles++;
                if (missCycles > StepTimeout) begin
                    abortRun("miss was not answered in time");
                end
                if (memRespValid) begin
                    compareBit("stall", stall, 1'b0);
                    compareBit("memReqValid", memReqValid, 1'b0);
                    expectPair(missAddr);
                    installLine(missAddr);
                    missOpen = 1'b0;
                end else begin
                    expectStalled();
                    if (memReqValid) begin
                        compareAddr("memReqAddr", memReqAddr, lineAlign(missAddr));
                    end
                end
            end else if (lookupValid) begin
                way = predictWay(lookupAddr);
                if (way >= 0) begin
                    compareBit("stall", stall, 1'b0);
                    compareBit("memReqValid", memReqValid, 1'b0);
                    expectPair(lookupAddr);
                    touchTree(lookupAddr, way);
                    hits++;
                end else begin
                    expectStalled();
                    compareBit("memReqValid", memReqValid, 1'b1);
                    compareAddr("memReqAddr", memReqAddr, lineAlign(lookupAddr));
                    missOpen   = 1'b1;
                    missAddr   = lookupAddr;
                    missCycles = 0;
                    misses++;
                end
            end
            // The coming edge takes the pc
            lookupValid = !stall && !memRespValid;
            lookupAddr  = pc;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic waitAccept();
        int waited;
        waited = 0;
        @(negedge clk);
        while (stall || memRespValid) begin
            waited++;
            if (waited > StepTimeout) begin
                abortRun("fetch address was not accepted in time");
            end
            @(negedge clk);
        end
    endtask

    task automatic issuePc(input AddrT a);
        pc = a;
        waitAccept();
        @(posedge clk);
        #1;
    endtask

    initial begin : stimulus
        int unsigned tagSel;
        int unsigned setSel;
        int unsigned wordSel;
        rst = 1'b1;
        pc  = '0;
        // Few sets and tags so lines get reused and evicted
        for (int i = 0; i < 200; i++) begin
            tagSel  = takeBits(3) % 6;
            setSel  = takeBits(2);
            wordSel = takeBits(2);
            randomPcs[i] = 32'h0004_0000 + tagSel * 32'h400 + setSel * 32'h10 + wordSel * 4;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        issuePc(32'h0000_1000);
        issuePc(32'h0000_1004);
        issuePc(32'h0000_1008);
        issuePc(32'h0000_100C);
        issuePc(32'h0000_1000);
        issuePc(32'h0000_101C);
        issuePc(32'h0000_1018);

        // Six tags into set 2, then back in reverse
        for (int k = 0; k < 6; k++) begin
            issuePc(32'h0000_2020 + AddrT'(k) * 32'h400);
        end
        for (int k = 0; k < 6; k++) begin
            issuePc(32'h0000_2028 + AddrT'(5 - k) * 32'h400);
        end

        foreach (randomPcs[i]) begin
            issuePc(randomPcs[i]);
        end
        waitAccept();
        @(posedge clk);
        $display("%0d hits and %0d misses checked", hits, misses);
        if (hits > 0 && misses > 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abortRun("the run saw no hits or no misses");
        end
    end

endmodule

/* src/fetchICache.sv */
`timescale 1ns/1ps

`include "icache_macros.svh"

module fetchICache
    import iCachePkg::*;
(
    input  logic clk,
    input  logic rst,
    input  AddrT pc,
    output logic slot0Valid,
    output AddrT slot0Pc,
    output InstT slot0Inst,
    output logic slot1Valid,
    output AddrT slot1Pc,
    output InstT slot1Inst,
    output logic stall,
    output logic memReqValid,
    output AddrT memReqAddr,
    input  logic memReqReady,
    input  logic memRespValid,
    input  LineT memRespLine
);

    AddrT                    lookupPc;
    logic                    fillEn;
    logic                    anyHit;
    logic [`ICACHE_WAYS-1:0] wayHit;
    logic [`ICACHE_WAYS-1:0] waySetValid;
    logic [`ICACHE_WAYS-1:0] wayFill;
    LineT                    wayLine [`ICACHE_WAYS];
    WayIdxT                  hitWay;
    WayIdxT                  victim;
    SetIdxT                  readSet;
    logic                    touchEn;
    WayIdxT                  touchWay;
    LineT                    pairLine;
    logic                    pairValid;

    // Hold the pending set while no new pc is taken
    assign readSet = (stall || fillEn) ? addrSet(lookupPc) : addrSet(pc);

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gWay
        assign wayFill[w] = fillEn && (victim == WayIdxT'(w));

        cacheWay uWay (
            .clk       (clk),
            .rst       (rst),
            .readSet   (readSet),
            .lookupTag (addrTag(lookupPc)),
            .fillEn    (wayFill[w]),
            .fillSet   (addrSet(lookupPc)),
            .fillTag   (addrTag(lookupPc)),
            .fillLine  (memRespLine),
            .hit       (wayHit[w]),
            .line      (wayLine[w]),
            .setValid  (waySetValid[w])
        );
    end

    assign anyHit = |wayHit;

    always_comb begin
        hitWay = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (wayHit[w]) begin
                hitWay = WayIdxT'(w);
            end
        end
    end

    assign touchEn  = (anyHit && !stall) || fillEn;
    assign touchWay = fillEn ? victim : hitWay;

    plruTracker uPlru (
        .clk      (clk),
        .rst      (rst),
        .set      (addrSet(lookupPc)),
        .touchEn  (touchEn),
        .touchWay (touchWay),
        .wayValid (waySetValid),
        .victim   (victim)
    );

    fetchControl uCtrl (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .anyHit       (anyHit),
        .memReqReady  (memReqReady),
        .memRespValid (memRespValid),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .stall        (stall),
        .lookupPc     (lookupPc),
        .fillEn       (fillEn)
    );

    ////////////////////
    // Instruction pair
    ////////////////////

    // Response line goes straight out on a fill
    assign pairLine  = fillEn ? memRespLine : wayLine[hitWay];
    assign pairValid = anyHit || fillEn;

    assign slot0Valid = pairValid && !lookupPc[2];
    assign slot1Valid = pairValid;
    assign slot0Pc    = {lookupPc[`ICACHE_ADDR_W-1:3], 3'b000};
    assign slot1Pc    = {lookupPc[`ICACHE_ADDR_W-1:3], 3'b100};
    assign slot0Inst  = pairLine[{lookupPc[3], 1'b0}];
    assign slot1Inst  = pairLine[{lookupPc[3], 1'b1}];

    oneWayHits: assert property (@(posedge clk) disable iff (rst) $onehot0(wayHit))
        else $error("more than one way hit");

    noPairWhileStalled: assert property (@(posedge clk) disable iff (rst)
        stall |-> !slot0Valid && !slot1Valid)
        else $error("instruction pair valid during stall");

endmodule

/* src/fetchControl.sv */
`timescale 1ns/1ps

module fetchControl
    import iCachePkg::*;
(
    input  logic clk,
    input  logic rst,
    input  AddrT pc,
    input  logic anyHit,
    input  logic memReqReady,
    input  logic memRespValid,
    output logic memReqValid,
    output AddrT memReqAddr,
    output logic stall,
    output AddrT lookupPc,
    output logic fillEn
);

    FetchStateT state;
    FetchStateT nextState;
    logic       pending;
    logic       miss;
    logic       accept;

    ////////////////////
    // Outputs
    ////////////////////

    // Only a lookup with a pc behind it can miss
    assign miss        = (state == Lookup) && pending && !anyHit;
    assign memReqValid = miss || (state == Request);
    assign memReqAddr  = lineBase(lookupPc);
    assign fillEn      = (state == Wait) && memRespValid;
    assign stall       = memReqValid || ((state == Wait) && !memRespValid);
    assign accept      = (state == Lookup) && !stall;

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        nextState = state;
        case (state)
            Lookup: begin
                if (miss) begin
                    nextState = memReqReady ? Wait : Request;
                end
            end
            Request: begin
                if (memReqReady) begin
                    nextState = Wait;
                end
            end
            Wait: begin
                if (memRespValid) begin
                    nextState = Lookup;
                end
            end
            default: begin
                nextState = Lookup;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= Lookup;
            pending  <= 1'b0;
            lookupPc <= '0;
        end else begin
            state   <= nextState;
            pending <= accept;
            if (accept) begin
                lookupPc <= pc;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    reqHeld: assert property (@(posedge clk) disable iff (rst)
        memReqValid && !memReqReady |=> memReqValid && $stable(memReqAddr))
        else $error("memory request dropped or changed under back-pressure");

    respInWait: assert property (@(posedge clk) disable iff (rst)
        memRespValid |-> state == Wait)
        else $error("memory response without an outstanding request");

endmodule

/* src/plruTracker.sv */
`timescale 1ns/1ps

`include "icache_macros.svh"

module plruTracker
    import iCachePkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  SetIdxT                  set,
    input  logic                    touchEn,
    input  WayIdxT                  touchWay,
    input  logic [`ICACHE_WAYS-1:0] wayValid,
    output WayIdxT                  victim
);

    PlruT plru [`ICACHE_SETS];
    PlruT cur;
    PlruT touched;

    assign cur = plru[set];

    // Point the tree away from the touched way
    always_comb begin
        touched = cur;
        case (touchWay)
            2'd0: begin
                touched[2] = 1'b1;
                touched[0] = 1'b1;
            end
            2'd1: begin
                touched[2] = 1'b1;
                touched[0] = 1'b0;
            end
            2'd2: begin
                touched[2] = 1'b0;
                touched[1] = 1'b1;
            end
            default: begin
                touched[2] = 1'b0;
                touched[1] = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                plru[s] <= '0;
            end
        end else if (touchEn) begin
            plru[set] <= touched;
        end
    end

    // Empty ways first, then follow the tree
    always_comb begin
        if (!wayValid[0]) begin
            victim = 2'd0;
        end else if (!wayValid[1]) begin
            victim = 2'd1;
        end else if (!wayValid[2]) begin
            victim = 2'd2;
        end else if (!wayValid[3]) begin
            victim = 2'd3;
        end else if (cur[2]) begin
            victim = cur[1] ? 2'd3 : 2'd2;
        end else begin
            victim = cur[0] ? 2'd1 : 2'd0;
        end
    end

    victimKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(victim))
        else $error("victim way is unknown");

endmodule

/* src/cacheWay.sv */
`timescale 1ns/1ps

`include "icache_macros.svh"

module cacheWay
    import iCachePkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  SetIdxT readSet,
    input  TagT    lookupTag,
    input  logic   fillEn,
    input  SetIdxT fillSet,
    input  TagT    fillTag,
    input  LineT   fillLine,
    output logic   hit,
    output LineT   line,
    output logic   setValid
);

    logic [`ICACHE_SETS-1:0] valid;
    SetIdxT ramAddr;
    SetIdxT setQ;
    logic   fillQ;
    TagT    tagRead;

    // Fill owns the RAM port
    assign ramAddr = fillEn ? fillSet : readSet;

    wayRam #(
        .PayloadT (TagT)
    ) tagRam (
        .clk       (clk),
        .writeEn   (fillEn),
        .addr      (ramAddr),
        .writeData (fillTag),
        .readData  (tagRead)
    );

    wayRam #(
        .PayloadT (LineT)
    ) dataRam (
        .clk       (clk),
        .writeEn   (fillEn),
        .addr      (ramAddr),
        .writeData (fillLine),
        .readData  (line)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            setQ  <= '0;
            fillQ <= 1'b0;
        end else begin
            if (fillEn) begin
                valid[fillSet] <= 1'b1;
            end
            setQ  <= readSet;
            fillQ <= fillEn;
        end
    end

    assign setValid = valid[setQ];

    // RAM output after a write cycle is not a lookup
    assign hit = !fillQ && setValid && (tagRead == lookupTag);

endmodule

/* src/wayRam.sv */
`timescale 1ns/1ps

`include "icache_macros.svh"

module wayRam
    import iCachePkg::*;
#(
    parameter type PayloadT = LineT
) (
    input  logic    clk,
    input  logic    writeEn,
    input  SetIdxT  addr,
    input  PayloadT writeData,
    output PayloadT readData
);

    PayloadT mem [`ICACHE_SETS];

    // Single port, read gives the old contents on a write
    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[addr] <= writeData;
        end
        readData <= mem[addr];
    end

endmodule

/* src/iCachePkg.sv */
`include "icache_macros.svh"

package iCachePkg;

    typedef logic [`ICACHE_ADDR_W-1:0]          AddrT;
    typedef logic [`ICACHE_TAG_W-1:0]           TagT;
    typedef logic [$clog2(`ICACHE_SETS)-1:0]    SetIdxT;
    typedef logic [$clog2(`ICACHE_WAYS)-1:0]    WayIdxT;
    typedef logic [`ICACHE_INST_W-1:0]          InstT;

    // Word k of a line sits in element k, word 0 at the low end
    typedef InstT [`ICACHE_LINE_BYTES*8/`ICACHE_INST_W-1:0] LineT;

    // Bit 2 picks the half, bit 0 the lower pair, bit 1 the upper pair
    typedef logic [2:0] PlruT;

    typedef enum logic [1:0] {
        Lookup,
        Request,
        Wait
    } FetchStateT;

    function automatic TagT addrTag(input AddrT addr);
        return addr[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
    endfunction

    function automatic SetIdxT addrSet(input AddrT addr);
        return addr[`ICACHE_TAG_LSB-1:`ICACHE_SET_LSB];
    endfunction

    function automatic AddrT lineBase(input AddrT addr);
        return addr & ~AddrT'(`ICACHE_LINE_BYTES - 1);
    endfunction

endpackage

/* src/icache_macros.svh */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

////////////////////
// Cache geometry
////////////////////

`define ICACHE_WAYS         4
`define ICACHE_SETS         64
`define ICACHE_LINE_BYTES   16

////////////////////
// Field widths
////////////////////

`define ICACHE_ADDR_W       32
`define ICACHE_TAG_W        22
`define ICACHE_INST_W       32

// Set index is addr[9:4], tag is addr[31:10]
`define ICACHE_SET_LSB      4
`define ICACHE_TAG_LSB      10

`endif
